// File: include/retire_macros.svh
// retire stage sizing macros: buffer depth, register counts, store-queue depth, index widths
`ifndef RETIRE_MACROS_SVH
`define RETIRE_MACROS_SVH

// reorder buffer entries.
`define ROB_DEPTH 16
`define ROB_IDX_W 4

// architectural register file.
`define NUM_ARCH_REGS 32
`define ARCH_W 5

// physical register file.
`define NUM_PHYS_REGS 64
`define PHYS_W 6

// store queue slots.
`define SQ_DEPTH 8
`define SQ_W 3

`endif

// File: hw/retire_pkg.sv
// retire stage types: entry kind, payload union, buffer entry, dispatch, completion, release
`include "retire_macros.svh"

package retire_pkg;

    typedef enum logic {
        KIND_REG   = 1'b0,
        KIND_STORE = 1'b1
    } entry_kind_t;

    // destination of a register-writing instruction.
    typedef struct packed {
        logic [`ARCH_W-1:0] arch;
        logic [`PHYS_W-1:0] phys;
    } reg_dest_t;

    // store slot, padded up to the register destination width.
    typedef struct packed {
        logic [`ARCH_W+`PHYS_W-`SQ_W-1:0] pad;
        logic [`SQ_W-1:0]                 slot;
    } store_dest_t;

    // one payload word, read according to the entry kind.
    typedef union packed {
        reg_dest_t   reg_dest;
        store_dest_t store_dest;
    } entry_payload_t;

    typedef struct packed {
        entry_kind_t    kind;
        entry_payload_t payload;
    } rob_entry_t;

    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] idx;
    } complete_t;

    typedef struct packed {
        logic               reg_free_valid;
        logic [`PHYS_W-1:0] free_phys;
        logic               st_rel_valid;
        logic [`SQ_W-1:0]   st_slot;
    } release_t;

endpackage

// File: hw/rob_buffer.sv
// circular reorder buffer: tail allocation, out-of-order completion marking, head presentation
`timescale 1ns/1ps
`include "retire_macros.svh"

module rob_buffer (
    input  logic                    CLK,
    input  logic                    rst,
    input  retire_pkg::dispatch_t   dispatch,
    input  retire_pkg::complete_t   complete,
    input  logic                    retire,
    output logic [`ROB_IDX_W-1:0]   alloc_idx,
    output logic                    rob_full,
    output logic                    head_valid,
    output logic                    head_done,
    output retire_pkg::rob_entry_t  head_entry
);

    logic [`ROB_IDX_W-1:0]  head_q;
    logic [`ROB_IDX_W-1:0]  tail_q;
    logic [`ROB_IDX_W:0]    count_q;
    logic [`ROB_DEPTH-1:0]  done_q;
    retire_pkg::rob_entry_t entry_mem [`ROB_DEPTH];

    logic                   accept;
    logic [`ROB_IDX_W-1:0]  cmp_offset;
    logic                   cmp_occupied;

    assign rob_full   = (count_q == (`ROB_IDX_W+1)'(`ROB_DEPTH));
    assign accept     = dispatch.valid && !rob_full;
    assign alloc_idx  = tail_q;

    assign head_valid = (count_q != '0);
    assign head_done  = done_q[head_q];
    assign head_entry = entry_mem[head_q];

    // distance from the head decides whether an index is live.
    assign cmp_offset   = complete.idx - head_q;
    assign cmp_occupied = ({1'b0, cmp_offset} < count_q);

    always_ff @(posedge CLK) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({accept, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            entry_mem[tail_q] <= dispatch.entry;
        end
    end

    // a fresh entry starts not done.
    always_ff @(posedge CLK) begin
        if (rst) begin
            done_q <= '0;
        end else begin
            if (accept) begin
                done_q[tail_q] <= 1'b0;
            end
            if (complete.valid) begin
                done_q[complete.idx] <= 1'b1;
            end
        end
    end

    // a held dispatch must not move the tail while full.
    a_no_accept_full: assert property (@(posedge CLK) disable iff (rst)
        dispatch.valid && rob_full |=> $stable(tail_q));

    a_complete_occupied: assert property (@(posedge CLK) disable iff (rst)
        complete.valid |-> cmp_occupied);

    // the controller pops only a finished head.
    a_retire_done: assert property (@(posedge CLK) disable iff (rst)
        retire |-> head_valid && head_done);

endmodule

// File: hw/retire_ctrl.sv
// retirement controller: commit decision, table update and registered release pulses
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_ctrl (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    head_valid,
    input  logic                    head_done,
    input  retire_pkg::rob_entry_t  head_entry,
    input  logic [`PHYS_W-1:0]      old_phys,
    output logic                    retire,
    output logic                    rat_we,
    output logic [`ARCH_W-1:0]      rat_arch,
    output logic [`PHYS_W-1:0]      rat_phys,
    output retire_pkg::release_t    release_out
);

    logic is_reg;
    logic is_store;
    logic free_reg;

    // single-wide commit of the oldest entry.
    assign retire   = head_valid && head_done;

    assign is_reg   = (head_entry.kind == retire_pkg::KIND_REG);
    assign is_store = (head_entry.kind == retire_pkg::KIND_STORE);

    assign rat_we   = retire && is_reg;
    assign rat_arch = head_entry.payload.reg_dest.arch;
    assign rat_phys = head_entry.payload.reg_dest.phys;

    // remapping onto the same register frees nothing.
    assign free_reg = rat_we && (old_phys != rat_phys);

    always_ff @(posedge CLK) begin
        release_out.free_phys <= old_phys;
        release_out.st_slot   <= head_entry.payload.store_dest.slot;
        if (rst) begin
            release_out.reg_free_valid <= 1'b0;
            release_out.st_rel_valid   <= 1'b0;
        end else begin
            release_out.reg_free_valid <= free_reg;
            release_out.st_rel_valid   <= retire && is_store;
        end
    end

    // one entry kind per retired slot.
    a_one_release: assert property (@(posedge CLK) disable iff (rst)
        !(release_out.reg_free_valid && release_out.st_rel_valid));

endmodule

// File: hw/retire_rat.sv
// retirement register alias table: identity reset, write port, old-value and read ports
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_rat (
    input  logic                CLK,
    input  logic                rst,
    input  logic                we,
    input  logic [`ARCH_W-1:0]  wr_arch,
    input  logic [`PHYS_W-1:0]  wr_phys,
    input  logic [`ARCH_W-1:0]  rd_arch,
    output logic [`PHYS_W-1:0]  old_phys,
    output logic [`PHYS_W-1:0]  rd_phys
);

    logic [`PHYS_W-1:0] map_q [`NUM_ARCH_REGS];

    // mapping as it stands before this edge's write.
    assign old_phys = map_q[wr_arch];
    assign rd_phys  = map_q[rd_arch];

    // architectural register i starts on physical register i.
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map_q[i] <= `PHYS_W'(i);
            end
        end else if (we) begin
            map_q[wr_arch] <= wr_phys;
        end
    end

endmodule

// File: hw/rat_wb_port.sv
// wishbone classic read-only slave over the alias table read port
`timescale 1ns/1ps
`include "retire_macros.svh"

module rat_wb_port (
    input  logic                CLK,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [`ARCH_W-1:0]  wb_adr,
    input  logic [`PHYS_W-1:0]  rd_phys,
    output logic                wb_ack,
    output logic [31:0]         wb_dat_o,
    output logic [`ARCH_W-1:0]  rd_arch
);

    logic rd_req;

    // address selects the architectural register directly.
    assign rd_arch = wb_adr;

    // writes get no acknowledge.
    assign rd_req  = wb_cyc && wb_stb && !wb_we;

    // ack for one cycle, then wait for the strobe to drop or repeat.
    always_ff @(posedge CLK) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= rd_req && !wb_ack;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_req) begin
            wb_dat_o <= 32'(rd_phys);
        end
    end

    a_ack_after_stb: assert property (@(posedge CLK) disable iff (rst)
        wb_ack |-> $past(rd_req));

endmodule

// File: hw/retire_unit.sv
// retire stage top: reorder buffer, retirement controller, alias table and its wishbone port
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_unit (
    input  logic                    CLK,
    input  logic                    rst,
    input  retire_pkg::dispatch_t   dispatch,
    input  retire_pkg::complete_t   complete,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ARCH_W-1:0]      wb_adr,
    output logic [`ROB_IDX_W-1:0]   alloc_idx,
    output logic                    rob_full,
    output retire_pkg::release_t    release_out,
    output logic                    wb_ack,
    output logic [31:0]             wb_dat_o
);

    logic                   head_valid;
    logic                   head_done;
    retire_pkg::rob_entry_t head_entry;
    logic                   retire;
    logic                   rat_we;
    logic [`ARCH_W-1:0]     rat_arch;
    logic [`PHYS_W-1:0]     rat_phys;
    logic [`PHYS_W-1:0]     old_phys;
    logic [`ARCH_W-1:0]     rd_arch;
    logic [`PHYS_W-1:0]     rd_phys;

    rob_buffer i_rob (
        .CLK        (CLK),
        .rst        (rst),
        .dispatch   (dispatch),
        .complete   (complete),
        .retire     (retire),
        .alloc_idx  (alloc_idx),
        .rob_full   (rob_full),
        .head_valid (head_valid),
        .head_done  (head_done),
        .head_entry (head_entry)
    );

    retire_ctrl i_ctrl (
        .CLK         (CLK),
        .rst         (rst),
        .head_valid  (head_valid),
        .head_done   (head_done),
        .head_entry  (head_entry),
        .old_phys    (old_phys),
        .retire      (retire),
        .rat_we      (rat_we),
        .rat_arch    (rat_arch),
        .rat_phys    (rat_phys),
        .release_out (release_out)
    );

    retire_rat i_rat (
        .CLK      (CLK),
        .rst      (rst),
        .we       (rat_we),
        .wr_arch  (rat_arch),
        .wr_phys  (rat_phys),
        .rd_arch  (rd_arch),
        .old_phys (old_phys),
        .rd_phys  (rd_phys)
    );

    rat_wb_port i_wb (
        .CLK      (CLK),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .rd_phys  (rd_phys),
        .wb_ack   (wb_ack),
        .wb_dat_o (wb_dat_o),
        .rd_arch  (rd_arch)
    );

endmodule

// File: dv/retire_unit_tb.sv
// testbench for the retire stage: directed tests, reference model, release monitor, watchdog
`timescale 1ns/1ps
`include "retire_macros.svh"

module retire_unit_tb;

    localparam int CLK_PERIOD_NS = 100;
    // cycles per test; a whole-table readback costs about four cycles a register.
    localparam int TEST_CYCLES = 5 + 140 + 200 + 200 + 130 + 40 + 1600;

    logic                   clk;
    logic                   rst;
    retire_pkg::dispatch_t  dispatch;
    retire_pkg::complete_t  complete;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`ARCH_W-1:0]     wb_adr;
    logic [`ROB_IDX_W-1:0]  alloc_idx;
    logic                   rob_full;
    retire_pkg::release_t   release_out;
    logic                   wb_ack;
    logic [31:0]            wb_dat_o;

    // reference model state.
    logic [`PHYS_W-1:0]     tbl_m [`NUM_ARCH_REGS];
    logic [`ROB_IDX_W-1:0]  tail_m;
    logic                   done_m [`ROB_DEPTH];
    logic [`ROB_IDX_W-1:0]  inflight [$];
    logic [`ROB_IDX_W-1:0]  pend [$];
    logic [7:0]             exp_rel [$];
    logic [7:0]             obs_rel [$];
    logic [31:0]            lfsr_q;

    retire_unit i_dut (
        .CLK         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .complete    (complete),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .alloc_idx   (alloc_idx),
        .rob_full    (rob_full),
        .release_out (release_out),
        .wb_ack      (wb_ack),
        .wb_dat_o    (wb_dat_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    // release codes: bit 7 marks a store slot, otherwise a freed physical register.
    always @(posedge clk) begin
        if (!rst && release_out.reg_free_valid) begin
            obs_rel.push_back({2'b00, release_out.free_phys});
        end
        if (!rst && release_out.st_rel_valid) begin
            obs_rel.push_back({5'b10000, release_out.st_slot});
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit.
    function automatic logic next_rand_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    function automatic retire_pkg::rob_entry_t reg_entry(input logic [`ARCH_W-1:0] arch,
                                                         input logic [`PHYS_W-1:0] phys);
        retire_pkg::rob_entry_t e;
        e.kind = retire_pkg::KIND_REG;
        e.payload.reg_dest.arch = arch;
        e.payload.reg_dest.phys = phys;
        return e;
    endfunction

    function automatic retire_pkg::rob_entry_t store_entry(input logic [`SQ_W-1:0] slot);
        retire_pkg::rob_entry_t e;
        e = '0;
        e.kind = retire_pkg::KIND_STORE;
        e.payload.store_dest.slot = slot;
        return e;
    endfunction

    // retire order is program order, so releases are predicted at dispatch.
    function automatic logic [`ROB_IDX_W-1:0] predict_dispatch(input retire_pkg::rob_entry_t e);
        logic [`ROB_IDX_W-1:0] idx;
        logic [`ARCH_W-1:0]    arch;
        idx = tail_m;
        tail_m = tail_m + 1'b1;
        done_m[idx] = 1'b0;
        inflight.push_back(idx);
        pend.push_back(idx);
        if (e.kind == retire_pkg::KIND_STORE) begin
            exp_rel.push_back({5'b10000, e.payload.store_dest.slot});
        end else begin
            arch = e.payload.reg_dest.arch;
            if (tbl_m[arch] != e.payload.reg_dest.phys) begin
                exp_rel.push_back({2'b00, tbl_m[arch]});
            end
            tbl_m[arch] = e.payload.reg_dest.phys;
        end
        return idx;
    endfunction

    function automatic void note_completion(input logic [`ROB_IDX_W-1:0] idx);
        done_m[idx] = 1'b1;
        for (int i = 0; i < pend.size(); i++) begin
            if (pend[i] == idx) begin
                pend.delete(i);
                break;
            end
        end
        while (inflight.size() > 0 && done_m[inflight[0]]) begin
            void'(inflight.pop_front());
        end
    endfunction

    task automatic wait_not_full();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rob_full) begin
            waited++;
            if (waited > 50) fail_run("buffer stayed full although entries were completed");
            @(negedge clk);
        end
    endtask

    task automatic dispatch_entry(input string name, input retire_pkg::rob_entry_t e,
                                  output logic [`ROB_IDX_W-1:0] idx);
        wait_not_full();
        check_value({name, " alloc_idx"}, 32'(tail_m), 32'(alloc_idx));
        @(posedge clk);
        dispatch <= {1'b1, e};
        @(posedge clk);
        dispatch.valid <= 1'b0;
        idx = predict_dispatch(e);
    endtask

    task automatic complete_entry(input logic [`ROB_IDX_W-1:0] idx);
        @(posedge clk);
        complete <= {1'b1, idx};
        @(posedge clk);
        complete.valid <= 1'b0;
        note_completion(idx);
    endtask

    task automatic wb_read(input string name, input int adr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= `ARCH_W'(adr);
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > 8) fail_run("wishbone read got no acknowledge");
            @(negedge clk);
        end
        check_value({name, " ack latency"}, 32'd1, 32'(waited));
        data = wb_dat_o;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        check_value({name, " ack width"}, 32'd0, 32'(wb_ack));
    endtask

    task automatic readback_table(input string name);
        logic [31:0] data;
        for (int a = 0; a < `NUM_ARCH_REGS; a++) begin
            wb_read($sformatf("%s reg %0d", name, a), a, data);
            check_value($sformatf("%s reg %0d", name, a), 32'(tbl_m[a]), data);
        end
    endtask

    // wait for the predicted pulses, then a little longer to catch extra ones.
    task automatic drain_releases(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (obs_rel.size() < exp_rel.size()) begin
            waited++;
            if (waited > 200) fail_run("release stream stalled before all entries retired");
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check_value({name, " count"}, 32'(exp_rel.size()), 32'(obs_rel.size()));
        while (exp_rel.size() > 0) begin
            check_value(name, 32'(exp_rel.pop_front()), 32'(obs_rel.pop_front()));
        end
        check_value({name, " buffer empty"}, 32'd0, 32'(i_dut.head_valid));
    endtask

    task automatic reset_readback();
        @(negedge clk);
        check_value("reset free valid", 32'd0, 32'(release_out.reg_free_valid));
        check_value("reset store valid", 32'd0, 32'(release_out.st_rel_valid));
        check_value("reset ack", 32'd0, 32'(wb_ack));
        check_value("reset full", 32'd0, 32'(rob_full));
        check_value("reset head valid", 32'd0, 32'(i_dut.head_valid));
        check_value("reset alloc_idx", 32'd0, 32'(alloc_idx));
        readback_table("reset readback");
    endtask

    // architectural registers repeat, so later entries free earlier new mappings.
    task automatic reg_reverse_order();
        logic [`ROB_IDX_W-1:0] ids [8];
        for (int i = 0; i < 8; i++) begin
            dispatch_entry("reg dispatch", reg_entry(`ARCH_W'(i % 5 + 1), `PHYS_W'(40 + i)),
                           ids[i]);
        end
        for (int i = 7; i >= 0; i--) begin
            complete_entry(ids[i]);
        end
        drain_releases("reg releases");
        readback_table("reg readback");
    endtask

    task automatic store_in_order();
        logic [`ROB_IDX_W-1:0] ids [8];
        for (int i = 0; i < 8; i++) begin
            dispatch_entry("store dispatch", store_entry(`SQ_W'(i * 3)), ids[i]);
        end
        for (int i = 0; i < 8; i += 2) begin
            complete_entry(ids[i + 1]);
        end
        for (int i = 0; i < 8; i += 2) begin
            complete_entry(ids[i]);
        end
        drain_releases("store releases");
        readback_table("store readback");
    endtask

    task automatic fill_and_hold();
        logic [`ROB_IDX_W-1:0]  first;
        logic [`ROB_IDX_W-1:0]  idx;
        retire_pkg::rob_entry_t held;
        first = tail_m;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            dispatch_entry("fill dispatch", store_entry(`SQ_W'(i)), idx);
        end
        @(negedge clk);
        check_value("fill full", 32'd1, 32'(rob_full));
        held = store_entry(`SQ_W'(5));
        @(posedge clk);
        dispatch <= {1'b1, held};
        repeat (3) begin
            @(negedge clk);
            check_value("hold full", 32'd1, 32'(rob_full));
            check_value("hold alloc_idx", 32'(first), 32'(alloc_idx));
        end
        complete_entry(first);
        wait_not_full();
        check_value("hold freed index", 32'(first), 32'(alloc_idx));
        @(posedge clk);
        dispatch.valid <= 1'b0;
        void'(predict_dispatch(held));
        @(negedge clk);
        check_value("hold accepted", 32'd1, 32'(rob_full));
        while (pend.size() > 0) begin
            complete_entry(pend[0]);
        end
        drain_releases("fill releases");
    endtask

    task automatic same_mapping();
        logic [`ROB_IDX_W-1:0] idx;
        logic [31:0]           data;
        dispatch_entry("same dispatch", reg_entry(`ARCH_W'(2), tbl_m[2]), idx);
        complete_entry(idx);
        drain_releases("same releases");
        wb_read("same readback", 2, data);
        check_value("same readback", 32'(tbl_m[2]), data);
    endtask

    task automatic random_mix();
        int                     n_disp;
        int                     pos;
        logic                   go;
        logic [31:0]            r;
        logic [`ROB_IDX_W-1:0]  idx;
        retire_pkg::rob_entry_t e;
        n_disp = 0;
        while (n_disp < 200 || pend.size() > 0) begin
            go = next_rand_bit();
            if (n_disp < 200 && inflight.size() < `ROB_DEPTH && (go || pend.size() == 0)) begin
                if (next_rand_bit()) begin
                    r = rand_bits(`SQ_W);
                    e = store_entry(r[`SQ_W-1:0]);
                end else begin
                    r = rand_bits(`ARCH_W + `PHYS_W);
                    e = reg_entry(r[`ARCH_W+`PHYS_W-1:`PHYS_W], r[`PHYS_W-1:0]);
                end
                dispatch_entry("random dispatch", e, idx);
                n_disp++;
            end else begin
                pos = int'(rand_bits(`ROB_IDX_W)) % pend.size();
                complete_entry(pend[pos]);
            end
        end
        drain_releases("random releases");
        readback_table("random readback");
    endtask

    initial begin
        rst      <= 1'b1;
        dispatch <= '0;
        complete <= '0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        lfsr_q = 32'd98983;
        tail_m = '0;
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            tbl_m[i] = `PHYS_W'(i);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_readback();
        reg_reverse_order();
        store_in_order();
        fill_and_hold();
        same_mapping();
        random_mix();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: retire_unit.f
+incdir+include
hw/retire_pkg.sv
hw/rob_buffer.sv
hw/retire_ctrl.sv
hw/retire_rat.sv
hw/rat_wb_port.sv
hw/retire_unit.sv
dv/retire_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= retire_unit_tb
FILELIST  ?= retire_unit.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
